//--- fpu_32.f
verilog/fpu_pkg.sv
verilog/fpu_op_if.sv
verilog/fp_op_decoder.sv
verilog/fpu_issue_ctrl.sv
verilog/fma_fp32.sv
verilog/srt_div_fp32.sv
verilog/fpu_result_sel.sv
verilog/fpu_32.sv
sim/fpu_32_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fpu_32_tb -f fpu_32.f -o fpu_32_sim

output=$(./obj_dir/fpu_32_sim || true)
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

//--- sim/fpu_32_tb.sv
module fpu_32_tb;
    import fpu_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int FMA_LAT      = 3;
    localparam int DIV_LAT      = 29;
    localparam int ILLEGAL_LAT  = 1;
    localparam int NUM_OPS      = 40;
    localparam int OP_CYCLES    = 30;
    localparam int MAX_WAIT     = 2 * OP_CYCLES;
    localparam int WATCHDOG     = (2 * NUM_OPS * OP_CYCLES + 4 * RESET_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst;
    logic        start;
    opcode_t     opcode;
    funct7_t     funct7;
    fp32_t       a;
    fp32_t       b;
    logic        busy;
    logic        done;
    fp32_t       result;
    logic        div_zero;
    logic        illegal;
    logic [31:0] lfsr_state;

    fpu_32 uut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .opcode   (opcode),
        .funct7   (funct7),
        .a        (a),
        .b        (b),
        .busy     (busy),
        .done     (done),
        .result   (result),
        .div_zero (div_zero),
        .illegal  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG);
        abort_run("watchdog expired before all tests finished");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_fp(input string name, input fp32_t got, input fp32_t exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] t=%0t %s: got %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("[ERROR] t=%0t %s latency: got %0d cycles, expected %0d",
                                $time, name, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // nonzero magnitude of n bits with a random sign
    function automatic int random_operand(input int n);
        int mag;
        mag = random_bits(n);
        if (mag == 0) begin
            mag = 1;
        end
        return (random_bits(1) != 0) ? -mag : mag;
    endfunction

    // exact float of an integer up to 24 significant bits
    function automatic fp32_t int_to_fp32(input int v);
        logic        s;
        int unsigned m;
        int          p;
        logic [22:0] f;
        if (v == 0) begin
            return '0;
        end
        s = (v < 0);
        m = s ? -v : v;
        p = 0;
        for (int i = 0; i < 32; i++) begin
            if (m[i]) begin
                p = i;
            end
        end
        if (p <= 23) begin
            f = 23'(m << (23 - p));
        end else begin
            f = 23'(m >> (p - 23));
        end
        return {s, 8'(EXP_BIAS + p), f};
    endfunction

    task automatic send_op(input opcode_t opc, input funct7_t f7, input fp32_t x, input fp32_t y);
        start  = 1'b1;
        opcode = opc;
        funct7 = f7;
        a      = x;
        b      = y;
        @(negedge clk);
        start  = 1'b0;
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (!done && cycles < MAX_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
            abort_run($sformatf("done never came within %0d cycles at t=%0t", MAX_WAIT, $time));
    endtask

    // legal op, checked at the cycle done is high
    task automatic check_op(input funct7_t f7, input fp32_t x, input fp32_t y,
                            input fp32_t expected, input string name);
        int cycles;
        send_op(OPC_OP_FP, f7, x, y);
        wait_done(cycles);
        check_latency(name, cycles, (f7 == F7_FDIV) ? DIV_LAT : FMA_LAT);
        check_fp(name, result, expected);
        check_flag("illegal", illegal, 1'b0);
        check_flag("div_zero", div_zero, 1'b0);
    endtask

    task automatic test_multiply();
        int x;
        int y;
        for (int i = 0; i < 6; i++) begin
            x = random_operand(11);
            y = random_operand(11);
            check_op(F7_FMUL, int_to_fp32(x), int_to_fp32(y), int_to_fp32(x * y), "mul result");
        end
        check_op(F7_FMUL, 32'h3FC00000, 32'h40000000, 32'h40400000, "mul 1.5*2.0");
    endtask

    task automatic test_add_sub();
        int x;
        int y;
        for (int i = 0; i < 6; i++) begin
            x = random_operand(20);
            y = random_operand(20);
            check_op(F7_FADD, int_to_fp32(x), int_to_fp32(y), int_to_fp32(x + y), "add result");
            check_op(F7_FSUB, int_to_fp32(x), int_to_fp32(y), int_to_fp32(x - y), "sub result");
        end
        x = random_operand(20);
        check_op(F7_FSUB, int_to_fp32(x), int_to_fp32(x), 32'h00000000, "sub x-x");
        // halfway cases settle on the even significand
        check_op(F7_FADD, 32'h4B800000, 32'h3F800000, 32'h4B800000, "add tie down");
        check_op(F7_FADD, 32'h4B800000, 32'h40400000, 32'h4B800002, "add tie up");
    endtask

    task automatic test_divide();
        int x;
        int y;
        int cycles;
        for (int i = 0; i < 4; i++) begin
            x = random_operand(11);
            y = random_operand(11);
            check_op(F7_FDIV, int_to_fp32(x * y), int_to_fp32(y), int_to_fp32(x), "div result");
        end
        check_op(F7_FDIV, 32'h3F800000, 32'h40400000, 32'h3EAAAAAB, "div 1/3");
        send_op(OPC_OP_FP, F7_FDIV, 32'h40A00000, 32'h00000000);
        wait_done(cycles);
        check_latency("div by zero", cycles, DIV_LAT);
        check_fp("div by zero result", result, 32'h00000000);
        check_flag("div_zero", div_zero, 1'b1);
    endtask

    // busy must cover the whole divide and drop as done rises
    task automatic test_divide_busy();
        int cycles;
        check_flag("busy", busy, 1'b0);
        send_op(OPC_OP_FP, F7_FDIV, 32'h40C00000, 32'h40000000);
        cycles = 0;
        while (!done && cycles < MAX_WAIT) begin
            check_flag("busy", busy, 1'b1);
            @(negedge clk);
            cycles++;
        end
        check_latency("divide", cycles, DIV_LAT);
        check_flag("busy", busy, 1'b0);
        check_fp("div 6/2", result, 32'h40400000);
    endtask

    task automatic test_illegal();
        int cycles;
        send_op(7'b0110011, F7_FADD, 32'h3F800000, 32'h40000000);
        wait_done(cycles);
        check_latency("bad opcode", cycles, ILLEGAL_LAT);
        check_flag("illegal", illegal, 1'b1);
        check_fp("bad opcode result", result, 32'h00000000);
        check_flag("div_zero", div_zero, 1'b0);
        send_op(OPC_OP_FP, 7'b0010000, 32'h3F800000, 32'h40000000);
        wait_done(cycles);
        check_latency("bad funct7", cycles, ILLEGAL_LAT);
        check_flag("illegal", illegal, 1'b1);
        check_fp("bad funct7 result", result, 32'h00000000);
    endtask

    task automatic test_pipeline();
        fp32_t expected [3];
        expected[0] = int_to_fp32(15);
        expected[1] = int_to_fp32(16);
        expected[2] = int_to_fp32(-8);
        start  = 1'b1;
        opcode = OPC_OP_FP;
        funct7 = F7_FMUL;
        a      = int_to_fp32(3);
        b      = int_to_fp32(5);
        @(negedge clk);
        funct7 = F7_FADD;
        a      = int_to_fp32(7);
        b      = int_to_fp32(9);
        @(negedge clk);
        funct7 = F7_FSUB;
        a      = int_to_fp32(2);
        b      = int_to_fp32(10);
        @(negedge clk);
        start  = 1'b0;
        check_flag("done", done, 1'b0);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_flag("done", done, 1'b1);
            check_fp("pipelined result", result, expected[i]);
        end
        @(negedge clk);
        check_flag("done", done, 1'b0);
    endtask

    task automatic test_range();
        check_op(F7_FMUL, 32'h71800000, 32'h71800000, 32'h7F800000, "mul overflow");
        check_op(F7_FMUL, 32'h0D800000, 32'h0D800000, 32'h00000000, "mul underflow");
        // subnormal operand reads as zero
        check_op(F7_FMUL, 32'h00400000, 32'h40400000, 32'h00000000, "mul subnormal");
        check_op(F7_FADD, 32'h00400000, 32'h40000000, 32'h40000000, "add subnormal");
    endtask

    initial begin
        rst        = 1'b0;
        start      = 1'b0;
        opcode     = '0;
        funct7     = '0;
        a          = '0;
        b          = '0;
        lfsr_state = 32'h18e855e8;
        repeat (RESET_CYCLES) @(negedge clk);
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("illegal", illegal, 1'b0);
        check_flag("div_zero", div_zero, 1'b0);
        rst = 1'b1;
        @(negedge clk);
        test_multiply();
        test_add_sub();
        test_divide();
        test_divide_busy();
        test_illegal();
        test_pipeline();
        test_range();
        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog/fpu_32.sv
module fpu_32 (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fpu_pkg::opcode_t opcode,
    input  fpu_pkg::funct7_t funct7,
    input  fpu_pkg::fp32_t   a,
    input  fpu_pkg::fp32_t   b,
    output logic             busy,
    output logic             done,
    output fpu_pkg::fp32_t   result,
    output logic             div_zero,
    output logic             illegal
);
    import fpu_pkg::*;

    fpu_op_e op;
    logic    reject;

    fpu_op_if fma_if ();
    fpu_op_if div_if ();

    fp_op_decoder u_decoder (
        .opcode (opcode),
        .funct7 (funct7),
        .op     (op)
    );

    fpu_issue_ctrl u_issue (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .a        (a),
        .b        (b),
        .busy     (busy),
        .fma      (fma_if.issue),
        .div      (div_if.issue),
        .reject   (reject),
        .div_done (div_if.done)
    );

    fma_fp32 u_fma (
        .clk  (clk),
        .rst  (rst),
        .port (fma_if.unit)
    );

    srt_div_fp32 u_div (
        .clk  (clk),
        .rst  (rst),
        .port (div_if.unit)
    );

    fpu_result_sel u_result (
        .clk      (clk),
        .rst      (rst),
        .fma      (fma_if.monitor),
        .div      (div_if.monitor),
        .reject   (reject),
        .done     (done),
        .result   (result),
        .div_zero (div_zero),
        .illegal  (illegal)
    );

endmodule

//--- verilog/fpu_result_sel.sv
module fpu_result_sel (
    input  logic           clk,
    input  logic           rst,
    fpu_op_if.monitor      fma,
    fpu_op_if.monitor      div,
    input  logic           reject,
    output logic           done,
    output fpu_pkg::fp32_t result,
    output logic           div_zero,
    output logic           illegal
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            done     <= 1'b0;
            div_zero <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            done     <= fma.done | div.done | reject;
            div_zero <= div.done & div.div_zero;
            // a unit result takes the slot over a reject
            illegal  <= reject & ~fma.done & ~div.done;
        end
    end

    always_ff @(posedge clk) begin
        if (fma.done) begin
            result <= fma.result;
        end else if (div.done) begin
            result <= div.result;
        end else begin
            result <= '0;
        end
    end

    // busy blocks FMA issue for the whole divide
    a_one_source: assert property (
        @(posedge clk) disable iff (!rst) !(fma.done && div.done)
    );

endmodule

//--- verilog/srt_div_fp32.sv
module srt_div_fp32 (
    input logic     clk,
    input logic     rst,
    fpu_op_if.unit  port
);
    import fpu_pkg::*;

    div_state_e          state;
    logic [4:0]          cnt;
    exp_t                ea;
    exp_t                eb;
    mant_t               ma;
    mant_t               mb;

    logic                sign;
    logic signed [9:0]   exp_diff;
    logic                a_zero;
    logic                b_zero;
    // remainder and divisor scaled by 2^25
    logic signed [27:0]  rem;
    logic signed [27:0]  dvs;
    logic [DIV_ITER-1:0] qp;
    logic [DIV_ITER-1:0] qn;

    logic signed [27:0]  rem2;
    logic signed [3:0]   top;
    logic                q_pos;
    logic                q_neg;
    logic signed [27:0]  rem_next;

    logic [DIV_ITER-1:0] quo;
    logic signed [27:0]  rem_fix;
    logic                rem_nz;
    logic [23:0]         mant;
    logic                guard;
    logic                sticky;
    logic                round_up;
    logic [24:0]         rounded;
    logic [22:0]         frac;
    logic signed [9:0]   exp_r;
    fp32_t               res;

    always_comb begin
        ea = port.a[FRAC_W+EXP_W-1:FRAC_W];
        eb = port.b[FRAC_W+EXP_W-1:FRAC_W];
        ma = (ea == '0) ? '0 : {1'b1, port.a[FRAC_W-1:0]};
        mb = (eb == '0) ? '0 : {1'b1, port.b[FRAC_W-1:0]};
    end

    // digit from the top four bits of 2r
    always_comb begin
        rem2  = rem <<< 1;
        top   = rem2[27:24];
        q_pos = (top >= 4'sd1);
        q_neg = (top <= -4'sd2);
        if (q_pos) begin
            rem_next = rem2 - dvs;
        end else if (q_neg) begin
            rem_next = rem2 + dvs;
        end else begin
            rem_next = rem2;
        end
    end

    always_comb begin
        // negative remainder means the quotient is one ulp high
        quo = qp - qn;
        if (rem < 0) begin
            quo = quo - 1'b1;
        end
        rem_fix = rem[27] ? (rem + dvs) : rem;
        rem_nz  = (rem_fix != '0);

        if (quo[DIV_ITER-1]) begin
            mant   = quo[DIV_ITER-1:2];
            guard  = quo[1];
            sticky = quo[0] | rem_nz;
            exp_r  = exp_diff;
        end else begin
            mant   = quo[DIV_ITER-2:1];
            guard  = quo[0];
            sticky = rem_nz;
            exp_r  = exp_diff - 10'sd1;
        end

        round_up = guard & (sticky | mant[0]);
        rounded  = {1'b0, mant} + 25'(round_up);
        if (rounded[24]) begin
            exp_r = exp_r + 10'sd1;
            frac  = rounded[23:1];
        end else begin
            frac  = rounded[22:0];
        end

        if (b_zero) begin
            res = '0;
        end else if (a_zero) begin
            res = {sign, 31'b0};
        end else if (exp_r >= 10'sd255) begin
            res = {sign, 8'hFF, 23'b0};
        end else if (exp_r <= 10'sd0) begin
            res = {sign, 31'b0};
        end else begin
            res = {sign, exp_r[7:0], frac};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= DIV_IDLE;
            cnt           <= '0;
            port.done     <= 1'b0;
            port.div_zero <= 1'b0;
        end else begin
            port.done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (port.start) begin
                        state <= DIV_ITERATE;
                        cnt   <= '0;
                    end
                end
                DIV_ITERATE: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(DIV_ITER - 1)) begin
                        state <= DIV_ROUND;
                    end
                end
                DIV_ROUND: begin
                    port.done     <= 1'b1;
                    port.div_zero <= b_zero;
                    state         <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (port.start) begin
                    sign     <= port.a[31] ^ port.b[31];
                    exp_diff <= 10'(ea) - 10'(eb) + 10'(EXP_BIAS);
                    a_zero   <= (ea == '0);
                    b_zero   <= (eb == '0);
                    // r0 = ma/4 and d = mb/2 keep |r| below d
                    rem      <= 28'(ma);
                    dvs      <= 28'({mb, 1'b0});
                    qp       <= '0;
                    qn       <= '0;
                end
            end
            DIV_ITERATE: begin
                rem <= rem_next;
                qp  <= {qp[DIV_ITER-2:0], q_pos};
                qn  <= {qn[DIV_ITER-2:0], q_neg};
            end
            DIV_ROUND: begin
                port.result <= res;
            end
            default: begin
                rem <= rem;
            end
        endcase
    end

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst) port.start |-> state == DIV_IDLE
    );

endmodule

//--- verilog/fma_fp32.sv
module fma_fp32 (
    input logic     clk,
    input logic     rst,
    fpu_op_if.unit  port
);
    import fpu_pkg::*;

    // stage 1 unpack and align
    logic               sa;
    logic               sb;
    logic               sc;
    exp_t               ea;
    exp_t               eb;
    exp_t               ec;
    mant_t              ma;
    mant_t              mb;
    mant_t              mc;
    logic [47:0]        prod;
    logic signed [9:0]  pe;
    logic signed [9:0]  ce;
    logic signed [9:0]  ed;
    logic               prod_zero;
    logic               add_zero;
    logic               swap;
    logic [50:0]        prod_sig;
    logic [50:0]        add_sig;
    logic [50:0]        big_sig;
    logic [50:0]        small_sig;
    logic signed [9:0]  big_exp;
    logic [6:0]         sh;
    logic [114:0]       shifted;

    logic               s1_valid;
    logic [50:0]        s1_big;
    logic [50:0]        s1_small;
    logic signed [9:0]  s1_exp;
    logic               s1_sign_big;
    logic               s1_sign_small;

    // stage 2 add, normalise, round
    logic               s1_sub;
    logic [51:0]        diff;
    logic [51:0]        mag;
    logic               sum_sign;
    logic [5:0]         lz;
    logic [51:0]        norm;
    logic               guard;
    logic               sticky;
    logic               round_up;
    logic [24:0]        rounded;
    logic [22:0]        frac;
    logic signed [9:0]  exp_n;
    fp32_t              res;

    logic               s2_valid;
    fp32_t              s2_result;

    function automatic logic [5:0] lead_zeros(input logic [51:0] v);
        logic [5:0] n;
        n = 6'd52;
        // highest set bit wins
        for (int i = 0; i < 52; i++) begin
            if (v[i]) begin
                n = 6'(51 - i);
            end
        end
        return n;
    endfunction

    always_comb begin
        sa = port.a[31];
        sb = port.b[31];
        sc = port.c[31];
        ea = port.a[FRAC_W+EXP_W-1:FRAC_W];
        eb = port.b[FRAC_W+EXP_W-1:FRAC_W];
        ec = port.c[FRAC_W+EXP_W-1:FRAC_W];
        // subnormals flush to zero
        ma = (ea == '0) ? '0 : {1'b1, port.a[FRAC_W-1:0]};
        mb = (eb == '0) ? '0 : {1'b1, port.b[FRAC_W-1:0]};
        mc = (ec == '0) ? '0 : {1'b1, port.c[FRAC_W-1:0]};

        prod      = ma * mb;
        prod_zero = (ma == '0) || (mb == '0);
        add_zero  = (mc == '0);
        pe        = 10'(ea) + 10'(eb) - 10'(EXP_BIAS);
        ce        = 10'(ec);

        // binary point sits below bit 49 for both operands
        prod_sig = {prod, 3'b000};
        add_sig  = {1'b0, mc, 26'b0};

        swap = prod_zero || (!add_zero && (ce > pe));
        if (swap) begin
            big_sig   = add_sig;
            small_sig = prod_sig;
            big_exp   = ce;
            ed        = ce - pe;
        end else begin
            big_sig   = prod_sig;
            small_sig = add_sig;
            big_exp   = pe;
            ed        = pe - ce;
        end

        if (ed < 10'sd0) begin
            sh = 7'd0;
        end else if (ed > 10'sd63) begin
            sh = 7'd63;
        end else begin
            sh = ed[6:0];
        end
        // bits shifted past the frame end up in the low half
        shifted = {small_sig, 64'b0} >> sh;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= port.start;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_big        <= big_sig;
        s1_small      <= shifted[114:64] | {50'b0, |shifted[63:0]};
        s1_exp        <= big_exp;
        s1_sign_big   <= swap ? sc : (sa ^ sb);
        s1_sign_small <= swap ? (sa ^ sb) : sc;
        s2_result     <= res;
    end

    always_comb begin
        s1_sub = s1_sign_big ^ s1_sign_small;
        diff   = {1'b0, s1_big} - {1'b0, s1_small};
        if (!s1_sub) begin
            mag      = {1'b0, s1_big} + {1'b0, s1_small};
            sum_sign = s1_sign_big;
        end else if (diff[51]) begin
            mag      = -diff;
            sum_sign = s1_sign_small;
        end else begin
            mag      = diff;
            sum_sign = s1_sign_big;
        end

        lz    = lead_zeros(mag);
        norm  = mag << lz;
        exp_n = s1_exp + 10'sd2 - $signed({4'b0000, lz});

        // one RNE rounding on the full sum
        guard    = norm[27];
        sticky   = |norm[26:0];
        round_up = guard & (sticky | norm[28]);
        rounded  = {1'b0, norm[51:28]} + 25'(round_up);
        if (rounded[24]) begin
            exp_n = exp_n + 10'sd1;
            frac  = rounded[23:1];
        end else begin
            frac  = rounded[22:0];
        end

        if (mag == '0) begin
            // exact zero is -0 only when both inputs were -0
            res = {s1_sign_big & s1_sign_small, 31'b0};
        end else if (exp_n >= 10'sd255) begin
            res = {sum_sign, 8'hFF, 23'b0};
        end else if (exp_n <= 10'sd0) begin
            res = {sum_sign, 31'b0};
        end else begin
            res = {sum_sign, exp_n[7:0], frac};
        end
    end

    assign port.done     = s2_valid;
    assign port.result   = s2_result;
    assign port.div_zero = 1'b0;

    a_fixed_latency: assert property (
        @(posedge clk) disable iff (!rst) port.done |-> $past(port.start, 2)
    );

endmodule

//--- verilog/fpu_issue_ctrl.sv
module fpu_issue_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  fpu_pkg::fpu_op_e op,
    input  fpu_pkg::fp32_t   a,
    input  fpu_pkg::fp32_t   b,
    output logic             busy,
    fpu_op_if.issue          fma,
    fpu_op_if.issue          div,
    output logic             reject,
    input  logic             div_done
);
    import fpu_pkg::*;

    logic accept;
    logic is_fma;

    // a request that arrives during a divide is dropped
    assign accept = start && !busy;
    assign is_fma = (op == FPU_MUL) || (op == FPU_ADD) || (op == FPU_SUB);

    // divider has no addend
    assign div.c = '0;

    always_ff @(posedge clk) begin
        if (!rst) begin
            fma.start <= 1'b0;
            div.start <= 1'b0;
            reject    <= 1'b0;
            busy      <= 1'b0;
        end else begin
            fma.start <= accept && is_fma;
            div.start <= accept && (op == FPU_DIV);
            reject    <= accept && (op == FPU_NONE);
            if (accept && (op == FPU_DIV)) begin
                busy <= 1'b1;
            end else if (div_done) begin
                busy <= 1'b0;
            end
        end
    end

    // all three ops share a*b+c
    always_ff @(posedge clk) begin
        if (accept && is_fma) begin
            fma.a <= a;
            case (op)
                FPU_MUL: begin
                    fma.b <= b;
                    fma.c <= '0;
                end
                FPU_ADD: begin
                    fma.b <= FP_ONE;
                    fma.c <= b;
                end
                default: begin
                    fma.b <= FP_ONE;
                    fma.c <= {~b[31], b[30:0]};
                end
            endcase
        end
        if (accept && (op == FPU_DIV)) begin
            div.a <= a;
            div.b <= b;
        end
    end

    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rst) start |-> !busy
    );

endmodule

//--- verilog/fp_op_decoder.sv
module fp_op_decoder (
    input  fpu_pkg::opcode_t opcode,
    input  fpu_pkg::funct7_t funct7,
    output fpu_pkg::fpu_op_e op
);
    import fpu_pkg::*;

    always_comb begin
        op = FPU_NONE;
        if (opcode == OPC_OP_FP) begin
            case (funct7)
                F7_FADD: op = FPU_ADD;
                F7_FSUB: op = FPU_SUB;
                F7_FMUL: op = FPU_MUL;
                F7_FDIV: op = FPU_DIV;
                default: op = FPU_NONE;
            endcase
        end
    end

endmodule

//--- verilog/fpu_op_if.sv
interface fpu_op_if;
    import fpu_pkg::*;

    // request side
    logic  start;
    fp32_t a;
    fp32_t b;
    fp32_t c;

    // response, valid only while done is high
    logic  done;
    fp32_t result;
    logic  div_zero;

    modport issue (output start, a, b, c);
    modport unit (input start, a, b, c, output done, result, div_zero);
    modport monitor (input done, result, div_zero);

endinterface

//--- verilog/fpu_pkg.sv
package fpu_pkg;

    // FP32 field widths
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int MANT_W = FRAC_W + 1;

    typedef logic [EXP_W+FRAC_W:0] fp32_t;
    typedef logic [EXP_W-1:0]      exp_t;
    // significand with the hidden bit in front
    typedef logic [MANT_W-1:0]     mant_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [6:0]            funct7_t;

    // 111 marks anything that did not decode
    typedef enum logic [2:0] {
        FPU_MUL  = 3'b000,
        FPU_ADD  = 3'b001,
        FPU_SUB  = 3'b010,
        FPU_DIV  = 3'b011,
        FPU_NONE = 3'b111
    } fpu_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_ITERATE,
        DIV_ROUND
    } div_state_e;

    localparam opcode_t OPC_OP_FP = 7'b1010011;
    localparam funct7_t F7_FADD   = 7'b0000000;
    localparam funct7_t F7_FSUB   = 7'b0000100;
    localparam funct7_t F7_FMUL   = 7'b0001000;
    localparam funct7_t F7_FDIV   = 7'b0001100;

    localparam fp32_t FP_ONE   = 32'h3F800000;
    localparam int    EXP_BIAS = 127;
    // 24 result bits plus guard and round
    localparam int    DIV_ITER = 26;

endpackage
